//--- verilog/smSysPkg.sv
// system bus and board types
package smSysPkg;

    typedef logic [31:0] word;
    typedef logic [31:0] memAddr;

    // board pacing selector
    typedef logic [3:0] divSel;

    // data memory request, core to RAM
    typedef struct packed {
        memAddr addr;
        logic   we;
        word    wData;
    } memReq;

endpackage

//--- verilog/smIsaPkg.sv
// MIPS subset instruction encoding
package smIsaPkg;

    typedef logic [4:0] regIdx;
    typedef logic [5:0] opcode;
    typedef logic [5:0] funct;
    typedef logic [15:0] immField;

    // major opcodes
    localparam opcode opRtype = 6'h00;
    localparam opcode opAddiu = 6'h09;
    localparam opcode opBeq   = 6'h04;
    localparam opcode opBne   = 6'h05;
    localparam opcode opLw    = 6'h23;
    localparam opcode opSw    = 6'h2b;

    // R-type function codes
    localparam funct fnAddu = 6'h21;
    localparam funct fnSubu = 6'h23;

    typedef struct packed {
        regIdx      rd;
        logic [4:0] shamt;
        funct       fn;
    } rFields;

    // low half is either the R-type fields or the immediate
    typedef union packed {
        rFields  r;
        immField imm;
    } lowFields;

    typedef struct packed {
        opcode    op;
        regIdx    rs;
        regIdx    rt;
        lowFields low;
    } instrFields;

endpackage

//--- verilog/smInputSync.sv
// two-stage input synchronizer
module smInputSync #(
    parameter int width = 1
) (
    input  logic             clk,
    input  logic [width-1:0] d,
    output logic [width-1:0] q
);
    // first stage may go metastable
    logic [width-1:0] stage1;

    always_ff @(posedge clk) begin
        stage1 <= d;
        q      <= stage1;
    end

endmodule

//--- verilog/smClkDivider.sv
// step pulse divider
module smClkDivider #(
    parameter int shift = 2
) (
    input  logic            clk,
    input  logic            rstN,
    input  smSysPkg::divSel divide,
    input  logic            enable,
    output logic            step
);
    import smSysPkg::*;

    word        count;
    logic [4:0] bitSel;
    logic       selBit;
    logic       prevBit;

    // rising edge of a divided clock with period 2^(shift + divide)
    assign bitSel = 5'(shift - 1) + 5'(divide);
    assign selBit = count[bitSel];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count   <= '0;
            prevBit <= 1'b0;
        end else begin
            if (enable) begin
                count <= count + 32'd1;
            end
            prevBit <= selBit;
        end
    end

    assign step = enable & selBit & ~prevBit;

    assert property (@(posedge clk) disable iff (!rstN) step |=> !step);

endmodule

//--- verilog/smRegFile.sv
// register file with debug port
module smRegFile (
    input  logic            clk,
    input  logic            rstN,
    input  logic            we,
    input  smIsaPkg::regIdx rs,
    input  smIsaPkg::regIdx rt,
    input  smIsaPkg::regIdx rd,
    input  smSysPkg::word   wd,
    output smSysPkg::word   rd1,
    output smSysPkg::word   rd2,
    input  smIsaPkg::regIdx dbgAddr,
    output smSysPkg::word   dbgData
);
    import smSysPkg::*;

    word regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin
            // r0 stays zero
            regs[rd] <= wd;
        end
    end

    assign rd1     = regs[rs];
    assign rd2     = regs[rt];
    assign dbgData = regs[dbgAddr];

endmodule

//--- verilog/smCpu.sv
// single-cycle MIPS subset core
module smCpu (
    input  logic            clk,
    input  logic            rstN,
    input  logic            step,
    output smSysPkg::memAddr imAddr,
    input  smSysPkg::word   imData,
    output smSysPkg::memReq dmReq,
    input  smSysPkg::word   dmRData,
    input  smIsaPkg::regIdx regAddr,
    output smSysPkg::word   regData
);
    import smSysPkg::*;
    import smIsaPkg::*;

    typedef struct packed {
        logic regWrite;
        logic regDst;
        logic aluSrcImm;
        logic aluSub;
        logic memToReg;
        logic memWrite;
        logic branchEq;
        logic branchNe;
    } ctrlBits;

    memAddr     pc;
    memAddr     pcPlus4;
    memAddr     pcBranch;
    memAddr     pcNext;
    instrFields instr;
    ctrlBits    ctrl;
    word        immExt;
    word        srcA;
    word        regB;
    word        srcB;
    word        aluResult;
    word        writeData;
    regIdx      writeIdx;
    logic       zero;
    logic       takeBranch;

    assign imAddr = pc;
    assign instr  = imData;
    assign immExt = {{16{instr.low.imm[15]}}, instr.low.imm};

    always_comb begin
        ctrl = '0;
        case (instr.op)
            opRtype: begin
                ctrl.regDst = 1'b1;
                case (instr.low.r.fn)
                    fnAddu: ctrl.regWrite = 1'b1;
                    fnSubu: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluSub   = 1'b1;
                    end
                    default: ;
                endcase
            end
            opAddiu: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opBeq: begin
                ctrl.aluSub   = 1'b1;
                ctrl.branchEq = 1'b1;
            end
            opBne: begin
                ctrl.aluSub   = 1'b1;
                ctrl.branchNe = 1'b1;
            end
            opLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memToReg  = 1'b1;
            end
            opSw: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
            end
            default: ;
        endcase
    end

    // register writes happen only on a step
    smRegFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .we      (ctrl.regWrite & step),
        .rs      (instr.rs),
        .rt      (instr.rt),
        .rd      (writeIdx),
        .wd      (writeData),
        .rd1     (srcA),
        .rd2     (regB),
        .dbgAddr (regAddr),
        .dbgData (regData)
    );

    assign srcB      = ctrl.aluSrcImm ? immExt : regB;
    assign aluResult = ctrl.aluSub ? srcA - srcB : srcA + srcB;
    assign zero      = (aluResult == '0);
    assign writeIdx  = ctrl.regDst ? instr.low.r.rd : instr.rt;
    assign writeData = ctrl.memToReg ? dmRData : aluResult;

    assign dmReq = '{addr: aluResult, we: ctrl.memWrite, wData: regB};

    // next pc
    assign takeBranch = (ctrl.branchEq & zero) | (ctrl.branchNe & ~zero);
    assign pcPlus4    = pc + 32'd4;
    assign pcBranch   = pcPlus4 + (immExt << 2);
    assign pcNext     = takeBranch ? pcBranch : pcPlus4;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (step) begin
            pc <= pcNext;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) step |=> (pc[1:0] == 2'b00));

endmodule

//--- verilog/smRom.sv
// instruction ROM
module smRom #(
    parameter int romWords = 64
) (
    input  smSysPkg::memAddr addr,
    output smSysPkg::word    data
);
    import smSysPkg::*;

    localparam int idxBits = $clog2(romWords);

    word         mem [romWords];
    logic [29:0] wordIdx;

    initial begin
        $readmemh("verilog/program.hex", mem);
    end

    // byte address to word index
    assign wordIdx = addr[31:2];
    assign data    = (wordIdx < 30'(romWords)) ? mem[wordIdx[idxBits-1:0]] : '0;

endmodule

//--- verilog/smRam.sv
// data RAM
module smRam #(
    parameter int ramWords = 64
) (
    input  logic            clk,
    input  smSysPkg::memReq req,
    input  logic            step,
    output smSysPkg::word   rData
);
    import smSysPkg::*;

    localparam int idxBits = $clog2(ramWords);

    word         mem [ramWords];
    logic [29:0] wordIdx;

    assign wordIdx = req.addr[31:2];

    always_ff @(posedge clk) begin
        if (req.we && step) begin
            mem[wordIdx[idxBits-1:0]] <= req.wData;
        end
    end

    assign rData = mem[wordIdx[idxBits-1:0]];

    // store address computed in the core must fit the RAM
    assert property (@(posedge clk) (req.we && step) |-> (wordIdx < 30'(ramWords)));

endmodule

//--- verilog/smTop.sv
// processor subsystem top
module smTop #(
    parameter int shift    = 2,
    parameter int romWords = 64,
    parameter int ramWords = 64
) (
    input  logic            clk,
    input  logic            rstN,
    input  smSysPkg::divSel clkDivide,
    input  logic            clkEnable,
    input  smIsaPkg::regIdx regAddr,
    output smSysPkg::word   regData,
    output logic            cpuStep
);
    import smSysPkg::*;
    import smIsaPkg::*;

    divSel  divideSync;
    logic   enableSync;
    regIdx  regAddrSync;
    memAddr imAddr;
    word    imData;
    memReq  dmReq;
    word    dmRData;

    // board controls are asynchronous
    smInputSync #(.width(4)) divSync_i (
        .clk (clk),
        .d   (clkDivide),
        .q   (divideSync)
    );

    smInputSync #(.width(1)) enSync_i (
        .clk (clk),
        .d   (clkEnable),
        .q   (enableSync)
    );

    smInputSync #(.width(5)) addrSync_i (
        .clk (clk),
        .d   (regAddr),
        .q   (regAddrSync)
    );

    smClkDivider #(.shift(shift)) divider_i (
        .clk    (clk),
        .rstN   (rstN),
        .divide (divideSync),
        .enable (enableSync),
        .step   (cpuStep)
    );

    smCpu cpu_i (
        .clk     (clk),
        .rstN    (rstN),
        .step    (cpuStep),
        .imAddr  (imAddr),
        .imData  (imData),
        .dmReq   (dmReq),
        .dmRData (dmRData),
        .regAddr (regAddrSync),
        .regData (regData)
    );

    smRom #(.romWords(romWords)) rom_i (
        .addr (imAddr),
        .data (imData)
    );

    smRam #(.ramWords(ramWords)) ram_i (
        .clk   (clk),
        .req   (dmReq),
        .step  (cpuStep),
        .rData (dmRData)
    );

endmodule

//--- verif/smChecker.sv
// step and register monitor
module smChecker #(
    parameter int shift = 2
) (
    input  logic            clk,
    input  logic            rstN,
    input  smSysPkg::divSel clkDivide,
    input  logic            clkEnable,
    input  smIsaPkg::regIdx regAddr,
    input  smSysPkg::word   regData,
    input  logic            cpuStep,
    input  logic            expValid,
    input  smSysPkg::word   expData,
    input  logic            freezeOn,
    input  logic            done,
    input  int              timeouts,
    output int              errors
);
    import smSysPkg::*;

    divSel lastDivide;
    logic  lastEnable;
    int    settle;
    int    goodSteps;
    int    gap;
    int    lowCycles;
    int    checks;
    logic  frozen;
    word   frozenVal;
    logic  reported;

    task automatic compare(input string name, input word got, input word exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // sampled mid-cycle, away from both edges of the stimulus
    always @(negedge clk) begin
        if (!rstN) begin
            errors     = 0;
            checks     = 0;
            settle     = 3;
            goodSteps  = 0;
            gap        = 0;
            lowCycles  = 0;
            frozen     = 1'b0;
            frozenVal  = '0;
            reported   = 1'b0;
            lastDivide = clkDivide;
            lastEnable = clkEnable;
        end else begin
            // pacing pins reach the divider two cycles late
            if (clkDivide != lastDivide || clkEnable != lastEnable) begin
                settle    = 3;
                goodSteps = 0;
            end
            lastDivide = clkDivide;
            lastEnable = clkEnable;
            lowCycles  = clkEnable ? 0 : lowCycles + 1;
            gap++;

            if (cpuStep) begin
                if (lowCycles >= 3) begin
                    compare("cpuStep (clkEnable low)", word'(cpuStep), '0);
                end
                // first settled step may follow a stale bit, so its gap is skipped
                if (settle == 0) begin
                    if (goodSteps >= 2) begin
                        compare("cpuStep gap", word'(gap), word'(1 << (shift + int'(clkDivide))));
                    end
                    goodSteps++;
                end
                gap = 0;
            end
            if (settle != 0) begin
                settle--;
            end

            if (freezeOn) begin
                if (!frozen) begin
                    frozenVal = regData;
                    frozen    = 1'b1;
                end else begin
                    compare("regData (r3 while disabled)", regData, frozenVal);
                end
            end else begin
                frozen = 1'b0;
            end

            if (expValid) begin
                compare($sformatf("regData (r%0d)", regAddr), regData, expData);
            end

            if (done && !reported) begin
                $display("Summary: %0d checks, %0d mismatches, %0d timeouts",
                         checks, errors, timeouts);
                reported = 1'b1;
            end
        end
    end

endmodule

//--- verif/smTb.sv
// processor subsystem testbench
module smTb;
    import smSysPkg::*;
    import smIsaPkg::*;

    localparam int shift = 2;

    logic  clk;
    logic  rstN;
    divSel clkDivide;
    logic  clkEnable;
    regIdx regAddr;
    word   regData;
    logic  cpuStep;
    logic  expValid;
    word   expData;
    logic  freezeOn;
    logic  done;
    int    timeouts;
    int    errors;
    int    stepCount;
    int    seed;

    smTop #(
        .shift    (shift),
        .romWords (64),
        .ramWords (64)
    ) smTop_i (
        .clk       (clk),
        .rstN      (rstN),
        .clkDivide (clkDivide),
        .clkEnable (clkEnable),
        .regAddr   (regAddr),
        .regData   (regData),
        .cpuStep   (cpuStep)
    );

    smChecker #(.shift(shift)) checker_i (
        .clk       (clk),
        .rstN      (rstN),
        .clkDivide (clkDivide),
        .clkEnable (clkEnable),
        .regAddr   (regAddr),
        .regData   (regData),
        .cpuStep   (cpuStep),
        .expValid  (expValid),
        .expData   (expData),
        .freezeOn  (freezeOn),
        .done      (done),
        .timeouts  (timeouts),
        .errors    (errors)
    );

    always #10 clk = ~clk;

    always @(negedge clk) begin
        if (!rstN) begin
            stepCount <= 0;
        end else if (cpuStep) begin
            stepCount <= stepCount + 1;
        end
    end

    // expected Fibonacci value, fib(0) = 0, fib(1) = 1
    function automatic word fib(input int n);
        word a;
        word b;
        word t;
        a = '0;
        b = 32'd1;
        for (int i = 0; i < n; i++) begin
            t = a + b;
            a = b;
            b = t;
        end
        return a;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic waitForStepCount(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (stepCount < target && cycles < limit) begin
            nextCycle();
            cycles++;
        end
        if (stepCount < target) begin
            $display("Timeout: only %0d of %0d steps seen after %0d cycles",
                     stepCount, target, limit);
            timeouts++;
        end
    endtask

    // debug address goes through the 2-cycle synchronizer
    task automatic checkReg(input regIdx idx, input word exp);
        regAddr = idx;
        repeat (3) nextCycle();
        expData  = exp;
        expValid = 1'b1;
        nextCycle();
        expValid = 1'b0;
    endtask

    task automatic runDivide(input divSel d);
        clkDivide = d;
        waitForStepCount(stepCount + 6, 400);
    endtask

    initial begin
        seed      = 32'h3055_9818;
        clk       = 1'b0;
        rstN      = 1'b0;
        clkDivide = '0;
        clkEnable = 1'b0;
        regAddr   = '0;
        expValid  = 1'b0;
        expData   = '0;
        freezeOn  = 1'b0;
        done      = 1'b0;
        timeouts  = 0;
        repeat (16) @(posedge clk);
        #2;
        rstN = 1'b1;

        for (int i = 0; i < 6; i++) begin
            checkReg(regIdx'(i), '0);
        end

        // pacing at three settings
        clkEnable = 1'b1;
        runDivide(4'd0);
        runDivide(4'd1);
        runDivide(divSel'({$random(seed)} % 4));

        // freeze in the middle of the loop
        regAddr   = 5'd3;
        clkEnable = 1'b0;
        repeat (4) nextCycle();
        freezeOn = 1'b1;
        repeat (200) nextCycle();
        freezeOn = 1'b0;

        clkDivide = '0;
        clkEnable = 1'b1;
        waitForStepCount(60, 1000);

        checkReg(5'd2, fib(10));
        checkReg(5'd1, fib(9));
        checkReg(5'd3, '0);
        checkReg(5'd5, fib(10));
        checkReg(5'd0, '0);

        done = 1'b1;
        repeat (2) nextCycle();
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/program.hex
// Fibonacci test program, one instruction word per line
// r1 = fib(n-1), r2 = fib(n), r3 counts ten iterations down, r6 holds 1
24010001 // 00: addiu r1, r0, 1
24020000 // 04: addiu r2, r0, 0
2403000A // 08: addiu r3, r0, 10
24060001 // 0c: addiu r6, r0, 1
00222021 // 10: addu  r4, r1, r2
00400821 // 14: addu  r1, r2, r0
00801021 // 18: addu  r2, r4, r0
00661823 // 1c: subu  r3, r3, r6
1460FFFB // 20: bne   r3, r0, 0x10
AC020000 // 24: sw    r2, 0(r0)
8C050000 // 28: lw    r5, 0(r0)
1000FFFF // 2c: beq   r0, r0, 0x2c

//--- sources.f
verilog/smSysPkg.sv
verilog/smIsaPkg.sv
verilog/smInputSync.sv
verilog/smClkDivider.sv
verilog/smRegFile.sv
verilog/smCpu.sv
verilog/smRom.sv
verilog/smRam.sv
verilog/smTop.sv
verif/smChecker.sv
verif/smTb.sv

//--- Makefile
# Verilator build and run of the processor subsystem
SIM      := verilator
FLAGS    := --binary --assert --timescale 1ns/1ps -j 0
TOP      := smTb
FILELIST := sources.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and scan $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
